//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIMFLAGS  = +verilator+error+limit+100
TOP       = adc_panel_tb
FILELIST  = vlog.f
PASS_MSG  = Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) $(SIMFLAGS))"; echo "$$out"; \
	  echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- hdl/adc_channel_capture.sv
/*
 * adc_channel_capture
 * registers adc channel a on the converter clock and brings the word
 * into the system clock domain, only a word both stages agree on passes
 */

`default_nettype none

module adc_channel_capture (
  input  logic                   adc_dco,
  input  board_pkg::adc_sample_t adc_d,
  input  logic                   fpga_clk_50,
  input  logic                   hps_fpga_reset_n,
  output board_pkg::adc_sample_t sys_sample
);

  import board_pkg::*;

  adc_sample_t dco_sample;  // adc_dco domain
  adc_sample_t sync_a;      // first system stage, may catch a changing word
  adc_sample_t sync_b;

  // ==================================================
  // converter clock domain
  // ==================================================
  always_ff @(posedge adc_dco or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) dco_sample <= '0;
    else                   dco_sample <= adc_d;
  end

  // ==================================================
  // system clock domain
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      sync_a     <= '0;
      sync_b     <= '0;
      sys_sample <= '0;
    end else begin
      sync_a <= dco_sample;
      sync_b <= sync_a;
      if (sync_a == sync_b) sys_sample <= sync_b;  // settled, else hold old word
    end
  end

endmodule

`default_nettype wire

//--- hdl/adc_panel_top.sv
/*
 * adc_panel_top
 * fpga side of the board top level, key debounce, hps reset request
 * pulses, heartbeat led and the adc channel a display
 */

`default_nettype none

`include "board_defs.svh"

module adc_panel_top #(
  parameter int debounce_cycles = `BOARD_DEBOUNCE_CYCLES,
  parameter int heartbeat_half  = `BOARD_HEARTBEAT_HALF
) (
  input  logic                      fpga_clk_50,
  input  logic                      hps_fpga_reset_n,
  input  board_pkg::key_vec_t       key,
  input  board_pkg::hps_reset_req_t hps_reset_req,    // request levels
  input  logic                      adc_dco,
  input  board_pkg::adc_sample_t    adc_d,
  output board_pkg::key_vec_t       debounced_keys,
  output board_pkg::hps_reset_req_t hps_reset_pulse,  // active high
  output logic                      heartbeat_led,
  output board_pkg::seg7_digits_t   hex_digits
);

  import board_pkg::*;

  adc_sample_t sys_sample;  // channel a in the 50 MHz domain

  // ==================================================
  // keys and heartbeat
  // ==================================================
  key_debounce #(
    .debounce_cycles (debounce_cycles)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .debounced_keys   (debounced_keys)
  );

  heartbeat_blinker #(
    .heartbeat_half (heartbeat_half)
  ) u_heartbeat_blinker (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .heartbeat_led    (heartbeat_led)
  );

  // ==================================================
  // hps reset request pulses
  // ==================================================
  reset_pulse_stretcher #(
    .pulse_cycles (`BOARD_COLD_PULSE)
  ) u_pulse_cold (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (hps_reset_req.cold),
    .pulse            (hps_reset_pulse.cold)
  );

  reset_pulse_stretcher #(
    .pulse_cycles (`BOARD_WARM_PULSE)
  ) u_pulse_warm (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (hps_reset_req.warm),
    .pulse            (hps_reset_pulse.warm)
  );

  reset_pulse_stretcher #(
    .pulse_cycles (`BOARD_DEBUG_PULSE)
  ) u_pulse_debug (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .request          (hps_reset_req.debug),
    .pulse            (hps_reset_pulse.debug)
  );

  // ==================================================
  // adc channel a to seven-segment
  // ==================================================
  adc_channel_capture u_adc_capture (
    .adc_dco          (adc_dco),
    .adc_d            (adc_d),
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sys_sample       (sys_sample)
  );

  sample_display u_sample_display (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .sys_sample       (sys_sample),
    .hex_digits       (hex_digits)   // 2 cycles behind sys_sample
  );

endmodule

`default_nettype wire

//--- hdl/board_defs.svh
/*
 * board constants for the panel logic
 * key and adc widths, debounce and heartbeat timeouts, reset pulse lengths
 */

`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// ==================================================
// widths
// ==================================================
`define BOARD_KEY_COUNT        4         // push keys, active low
`define BOARD_ADC_WIDTH        14        // adc channel a sample
`define BOARD_SEG_DIGITS       4         // decimal digits on hex3..hex0

// ==================================================
// timeouts in fpga_clk_50 cycles
// ==================================================
`define BOARD_DEBOUNCE_CYCLES  50000     // 1 ms at 50 MHz
`define BOARD_HEARTBEAT_HALF   25000000  // half period of the led, 0.5 s

// reset request pulse lengths toward the hard processor
`define BOARD_COLD_PULSE       6
`define BOARD_WARM_PULSE       2
`define BOARD_DEBUG_PULSE      32

`endif

//--- hdl/board_pkg.sv
/*
 * board_pkg
 * packed types for keys, reset requests, adc samples and display codes,
 * plus the hex glyph decoder for the seven-segment outputs
 */

`default_nettype none

`include "board_defs.svh"

package board_pkg;

  typedef logic [`BOARD_KEY_COUNT-1:0] key_vec_t;   // 0 = pressed
  typedef logic [`BOARD_ADC_WIDTH-1:0] adc_sample_t; // unsigned

  // one bit per hps reset kind, levels in and pulses out
  typedef struct packed {
    logic cold;
    logic warm;
    logic debug;
  } hps_reset_req_t;

  typedef struct packed {
    logic [3:0] thousands;
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
  } bcd_digits_t;

  typedef logic [6:0] seg7_t;  // g..a, segment lit when 0

  typedef struct packed {
    seg7_t hex3;  // most significant digit
    seg7_t hex2;
    seg7_t hex1;
    seg7_t hex0;
  } seg7_digits_t;

  // hex glyphs, a..f shown as A b C d E F
  function automatic seg7_t seg7_decode(input logic [3:0] value);
    seg7_t seg;
    case (value)
      4'h0:    seg = 7'b1000000;
      4'h1:    seg = 7'b1111001;
      4'h2:    seg = 7'b0100100;
      4'h3:    seg = 7'b0110000;
      4'h4:    seg = 7'b0011001;
      4'h5:    seg = 7'b0010010;
      4'h6:    seg = 7'b0000010;
      4'h7:    seg = 7'b1111000;
      4'h8:    seg = 7'b0000000;
      4'h9:    seg = 7'b0011000;
      4'ha:    seg = 7'b0001000;
      4'hb:    seg = 7'b0000011;
      4'hc:    seg = 7'b1000110;
      4'hd:    seg = 7'b0100001;
      4'he:    seg = 7'b0000110;
      4'hf:    seg = 7'b0001110;
      default: seg = 7'b1111111;  // blank
    endcase
    return seg;
  endfunction

endpackage

`default_nettype wire

//--- hdl/heartbeat_blinker.sv
/*
 * heartbeat_blinker
 * free-running divider that toggles the heartbeat led
 * every heartbeat_half clocks
 */

`default_nettype none

module heartbeat_blinker #(
  parameter int heartbeat_half = 25000000
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic heartbeat_led
);

  localparam int cnt_w = (heartbeat_half > 1) ? $clog2(heartbeat_half) : 1;

  logic [cnt_w-1:0] half_cnt;  // 0 .. heartbeat_half-1

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      half_cnt      <= '0;
      heartbeat_led <= 1'b0;  // off after reset
    end else if (half_cnt == cnt_w'(heartbeat_half - 1)) begin
      half_cnt      <= '0;               // wrap
      heartbeat_led <= ~heartbeat_led;   // toggle once per wrap
    end else begin
      half_cnt <= half_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hdl/key_debounce.sv
/*
 * key_debounce
 * synchronizes each push key and passes its level on only after it
 * has held steady for debounce_cycles clocks
 */

`default_nettype none

`include "board_defs.svh"

module key_debounce #(
  parameter int debounce_cycles = `BOARD_DEBOUNCE_CYCLES
) (
  input  logic                fpga_clk_50,
  input  logic                hps_fpga_reset_n,
  input  board_pkg::key_vec_t key,
  output board_pkg::key_vec_t debounced_keys
);

  import board_pkg::*;

  localparam int cnt_w = $clog2(debounce_cycles + 1);

  key_vec_t key_meta;  // first sync stage
  key_vec_t key_sync;  // safe to use from here on

  // ==================================================
  // two-flop synchronizer, all keys
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      key_meta <= '1;  // released
      key_sync <= '1;
    end else begin
      key_meta <= key;
      key_sync <= key_meta;
    end
  end

  // ==================================================
  // per key stability counter
  // ==================================================
  for (genvar i = 0; i < `BOARD_KEY_COUNT; i++) begin : g_key
    logic [cnt_w-1:0] stable_cnt;  // cycles the input has differed
    logic             key_state;   // debounced level

    always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
      if (!hps_fpga_reset_n) begin
        stable_cnt <= '0;
        key_state  <= 1'b1;
      end else if (key_sync[i] == key_state) begin
        stable_cnt <= '0;  // no change pending, or a glitch ended
      end else if (stable_cnt == cnt_w'(debounce_cycles - 1)) begin
        key_state  <= key_sync[i];  // held long enough
        stable_cnt <= '0;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end

    assign debounced_keys[i] = key_state;
  end

endmodule

`default_nettype wire

//--- hdl/reset_pulse_stretcher.sv
/*
 * reset_pulse_stretcher
 * turns a rising edge of a reset request level into a pulse of
 * pulse_cycles clocks, edges seen while the pulse runs are dropped
 */

`default_nettype none

module reset_pulse_stretcher #(
  parameter int pulse_cycles = 2
) (
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic request,
  output logic pulse
);

  localparam int cnt_w = $clog2(pulse_cycles + 1);

  logic             request_q;     // registered request
  logic             request_prev;  // one sample older
  logic             request_rise;
  logic [cnt_w-1:0] pulse_cnt;     // cycles of pulse left

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      request_q    <= 1'b0;
      request_prev <= 1'b0;
    end else begin
      request_q    <= request;
      request_prev <= request_q;
    end
  end

  assign request_rise = request_q & ~request_prev;

  // ==================================================
  // pulse length counter
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      pulse_cnt <= '0;
    end else if (pulse_cnt != '0) begin
      pulse_cnt <= pulse_cnt - 1'b1;  // busy, any new edge is ignored
    end else if (request_rise) begin
      pulse_cnt <= cnt_w'(pulse_cycles);
    end
  end

  assign pulse = (pulse_cnt != '0);  // high from the cycle after the edge

endmodule

`default_nettype wire

//--- hdl/sample_display.sv
/*
 * sample_display
 * two-stage pipeline, binary sample to four decimal digits, then digits
 * to active-low segment codes on hex3..hex0
 */

`default_nettype none

`include "board_defs.svh"

module sample_display (
  input  logic                    fpga_clk_50,
  input  logic                    hps_fpga_reset_n,
  input  board_pkg::adc_sample_t  sys_sample,
  output board_pkg::seg7_digits_t hex_digits
);

  import board_pkg::*;

  bcd_digits_t bcd_next;  // stage 1 input, combinational
  bcd_digits_t bcd_q;     // stage 1 register

  // ==================================================
  // stage 1, decimal split by repeated division by ten
  // ==================================================
  always_comb begin
    adc_sample_t rest;
    logic [3:0]  digit [`BOARD_SEG_DIGITS];
    rest = sys_sample;
    for (int i = 0; i < `BOARD_SEG_DIGITS; i++) begin
      digit[i] = 4'(rest % 10);  // lowest remaining digit
      rest     = rest / 10;
    end
    // digits above the fourth are dropped, so the value wraps at 10000
    bcd_next.ones      = digit[0];
    bcd_next.tens      = digit[1];
    bcd_next.hundreds  = digit[2];
    bcd_next.thousands = digit[3];
  end

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) bcd_q <= '0;
    else                   bcd_q <= bcd_next;
  end

  // ==================================================
  // stage 2, segment decode
  // ==================================================
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      hex_digits.hex3 <= seg7_decode(4'd0);  // shows 0000
      hex_digits.hex2 <= seg7_decode(4'd0);
      hex_digits.hex1 <= seg7_decode(4'd0);
      hex_digits.hex0 <= seg7_decode(4'd0);
    end else begin
      hex_digits.hex3 <= seg7_decode(bcd_q.thousands);
      hex_digits.hex2 <= seg7_decode(bcd_q.hundreds);
      hex_digits.hex1 <= seg7_decode(bcd_q.tens);
      hex_digits.hex0 <= seg7_decode(bcd_q.ones);
    end
  end

endmodule

`default_nettype wire

//--- tb/adc_panel_assert.sv
/*
 * adc_panel_assert
 * concurrent checks on the panel top level, reset pulse lengths,
 * quiet pulses in reset and known display codes
 */

`default_nettype none

`include "board_defs.svh"

module adc_panel_assert (
  input logic                      fpga_clk_50,
  input logic                      hps_fpga_reset_n,
  input board_pkg::hps_reset_req_t hps_reset_pulse,
  input board_pkg::seg7_digits_t   hex_digits
);

  timeunit 1ns;
  timeprecision 100ps;

  import board_pkg::*;

  int          fail_count = 0;  // read by the testbench at the end
  int unsigned run_cold;        // high samples in a row
  int unsigned run_warm;
  int unsigned run_debug;

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n) begin
    if (!hps_fpga_reset_n) begin
      run_cold  <= 0;
      run_warm  <= 0;
      run_debug <= 0;
    end else begin
      run_cold  <= hps_reset_pulse.cold  ? run_cold + 1  : 0;
      run_warm  <= hps_reset_pulse.warm  ? run_warm + 1  : 0;
      run_debug <= hps_reset_pulse.debug ? run_debug + 1 : 0;
    end
  end

  // ==================================================
  // once up, each pulse stays up for exactly its length
  // ==================================================
  cold_length: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    run_cold != 0 |-> hps_reset_pulse.cold == (run_cold < `BOARD_COLD_PULSE))
    else begin fail_count++; $error("cold reset pulse has the wrong length"); end

  warm_length: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    run_warm != 0 |-> hps_reset_pulse.warm == (run_warm < `BOARD_WARM_PULSE))
    else begin fail_count++; $error("warm reset pulse has the wrong length"); end

  debug_length: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    run_debug != 0 |-> hps_reset_pulse.debug == (run_debug < `BOARD_DEBUG_PULSE))
    else begin fail_count++; $error("debug reset pulse has the wrong length"); end

  // no pulse toward the hps while the fabric is in reset
  quiet_in_reset: assert property (@(posedge fpga_clk_50)
    !hps_fpga_reset_n |-> hps_reset_pulse == 3'b000)
    else begin fail_count++; $error("reset pulse high during reset"); end

  digits_known: assert property (@(posedge fpga_clk_50) disable iff (!hps_fpga_reset_n)
    !$isunknown(hex_digits))
    else begin fail_count++; $error("hex_digits has unknown bits"); end

endmodule

bind adc_panel_top adc_panel_assert u_adc_panel_assert (
  .fpga_clk_50      (fpga_clk_50),
  .hps_fpga_reset_n (hps_fpga_reset_n),
  .hps_reset_pulse  (hps_reset_pulse),
  .hex_digits       (hex_digits)
);

`default_nettype wire

//--- tb/adc_panel_tb.sv
/*
 * adc_panel_tb
 * random stimulus for the panel top level, keys, reset requests,
 * heartbeat and adc display, checked against a model kept here
 */

`default_nettype none

`include "board_defs.svh"

module adc_panel_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import board_pkg::*;

  localparam int deb_cycles    = 20;
  localparam int hb_half       = 40;
  localparam int glitch_rounds = 12;
  localparam int level_rounds  = 12;
  localparam int level_hold    = 30;
  localparam int pulse_rounds  = 9;   // three per request field
  localparam int adc_samples   = 40;
  localparam int adc_hold      = 20;
  // phase budgets in cycles plus a margin
  localparam int cycle_limit   = 16 + glitch_rounds * 21 + level_rounds * level_hold
                                 + pulse_rounds * 48 + 7 * hb_half
                                 + adc_samples * adc_hold + 200;

  logic           fpga_clk_50;
  logic           adc_dco;
  logic           hps_fpga_reset_n;
  key_vec_t       key;
  hps_reset_req_t hps_reset_req;
  adc_sample_t    adc_d;
  key_vec_t       debounced_keys;
  hps_reset_req_t hps_reset_pulse;
  logic           heartbeat_led;
  seg7_digits_t   hex_digits;
  int unsigned    run_cycles = 0;  // edges since reset release

  // dco phase keeps its edges off the input drive times
  tb_clock_gen #(.period(8.0))               u_sys_clk (.clk(fpga_clk_50));
  tb_clock_gen #(.period(14.0), .phase(2.5)) u_dco_clk (.clk(adc_dco));

  adc_panel_top #(
    .debounce_cycles (deb_cycles),
    .heartbeat_half  (hb_half)
  ) UUT (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .hps_reset_req    (hps_reset_req),
    .adc_dco          (adc_dco),
    .adc_d            (adc_d),
    .debounced_keys   (debounced_keys),
    .hps_reset_pulse  (hps_reset_pulse),
    .heartbeat_led    (heartbeat_led),
    .hex_digits       (hex_digits)
  );

  // ==================================================
  // helpers and model
  // ==================================================
  task automatic stop_with_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic tick();
    @(posedge fpga_clk_50);
    #1;  // outputs settled and inputs safe to drive
  endtask

  task automatic check_keys(input key_vec_t got, input key_vec_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERROR at %0t ns: debounced_keys = %b, expected %b",
                                $time, got, exp));
  endtask

  task automatic check_pulse(input hps_reset_req_t got, input hps_reset_req_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERROR at %0t ns: hps_reset_pulse = %b, expected %b",
                                $time, got, exp));
  endtask

  task automatic check_led(input logic got, input logic exp);
    if (got !== exp)
      stop_with_error($sformatf("ERROR at %0t ns: heartbeat_led = %b, expected %b",
                                $time, got, exp));
  endtask

  task automatic check_digits(input seg7_digits_t got, input seg7_digits_t exp);
    if (got !== exp)
      stop_with_error($sformatf("ERROR at %0t ns: hex_digits = %h, expected %h",
                                $time, got, exp));
  endtask

  function automatic seg7_t glyph(input int digit);  // active-low glyph on bits g..a
    case (digit)
      0: return 7'h40;
      1: return 7'h79;
      2: return 7'h24;
      3: return 7'h30;
      4: return 7'h19;
      5: return 7'h12;
      6: return 7'h02;
      7: return 7'h78;
      8: return 7'h00;
      9: return 7'h18;
      default: return 7'h7f;
    endcase
  endfunction

  function automatic seg7_digits_t expected_digits(input adc_sample_t sample);
    int           value;
    seg7_digits_t exp;
    value    = int'(sample) % 10000;  // only four digits shown
    exp.hex3 = glyph(value / 1000);
    exp.hex2 = glyph((value / 100) % 10);
    exp.hex1 = glyph((value / 10) % 10);
    exp.hex0 = glyph(value % 10);
    return exp;
  endfunction

  function automatic int pulse_length(input int sel);  // bit index in the struct
    case (sel)
      2:       return `BOARD_COLD_PULSE;
      1:       return `BOARD_WARM_PULSE;
      default: return `BOARD_DEBUG_PULSE;
    endcase
  endfunction

  always @(posedge fpga_clk_50) begin
    if (hps_fpga_reset_n) run_cycles <= run_cycles + 1;
    if (UUT.u_adc_panel_assert.fail_count != 0)
      stop_with_error("a bound assertion on the top level failed");
    else if (run_cycles >= cycle_limit)
      stop_with_error($sformatf("run passed the limit of %0d cycles without finishing",
                                cycle_limit));
  end

  // ==================================================
  // stimulus
  // ==================================================
  initial begin
    key_vec_t       stable_keys;
    key_vec_t       new_keys;
    int             sel;
    int             plen;
    int             drop_at;
    logic           extra_edge;
    logic [2:0]     req_bits;
    hps_reset_req_t exp_pulse;
    int             toggles;
    logic           last_led;
    adc_sample_t    sample;

    void'($urandom(35379));
    hps_fpga_reset_n = 1'b0;
    key              = '1;   // released
    hps_reset_req    = '0;
    adc_d            = '0;
    repeat (8) @(posedge fpga_clk_50);
    #1 hps_fpga_reset_n = 1'b1;

    check_keys(debounced_keys, '1);
    check_pulse(hps_reset_pulse, '0);
    check_led(heartbeat_led, 1'b0);
    check_digits(hex_digits, expected_digits('0));

    // short glitches must not move the debounced level
    stable_keys = '1;
    for (int r = 0; r < glitch_rounds; r++) begin
      key = stable_keys ^ key_vec_t'($urandom_range(15, 1));
      repeat ($urandom_range(9, 1)) begin
        tick();
        check_keys(debounced_keys, stable_keys);
      end
      key = stable_keys;
      repeat (12) begin
        tick();
        check_keys(debounced_keys, stable_keys);
      end
    end

    // held levels settle within deb_cycles + 3
    for (int r = 0; r < level_rounds; r++) begin
      new_keys = key_vec_t'($urandom_range(15, 0));
      key      = new_keys;
      for (int i = 1; i <= level_hold; i++) begin
        tick();
        if (i >= deb_cycles + 3)
          check_keys(debounced_keys, new_keys);
        else if (((debounced_keys ^ stable_keys) & ~(stable_keys ^ new_keys)) != '0)
          stop_with_error("debounced_keys moved a key whose input did not change");
      end
      stable_keys = new_keys;
    end

    // reset pulses high on ticks 2..len+1 after the rising edge
    for (int r = 0; r < pulse_rounds; r++) begin
      sel           = r % 3;
      plen          = pulse_length(sel);
      req_bits      = 3'b001 << sel;
      extra_edge    = 1'($urandom_range(1, 0));
      drop_at       = int'($urandom_range(plen - 1, 1));
      hps_reset_req = hps_reset_req_t'(req_bits);
      for (int t = 1; t <= plen + 8; t++) begin
        tick();
        if (t >= 2 && t <= plen + 1) exp_pulse = hps_reset_req_t'(req_bits);
        else                         exp_pulse = '0;
        check_pulse(hps_reset_pulse, exp_pulse);
        if (extra_edge && t == drop_at)     hps_reset_req = '0;  // re-arm inside pulse
        if (extra_edge && t == drop_at + 1) hps_reset_req = hps_reset_req_t'(req_bits);
        if (t == plen + 2)                  hps_reset_req = '0;
      end
      repeat ($urandom_range(4, 0)) begin
        tick();
        check_pulse(hps_reset_pulse, '0);
      end
    end

    // heartbeat toggles every hb_half edges counted from reset release
    toggles  = 0;
    last_led = heartbeat_led;
    while (toggles < 6) begin
      tick();
      check_led(heartbeat_led, ((run_cycles / hb_half) % 2) == 1);
      if (heartbeat_led != last_led) toggles++;
      last_led = heartbeat_led;
    end

    // adc samples with the extremes first
    for (int s = 0; s < adc_samples; s++) begin
      case (s)
        0:       sample = 14'd0;
        1:       sample = 14'd9999;
        2:       sample = 14'd10000;
        3:       sample = 14'd16383;
        default: sample = adc_sample_t'($urandom_range(16383, 0));
      endcase
      adc_d = sample;
      repeat (adc_hold) tick();
      check_digits(hex_digits, expected_digits(sample));
    end

    tick();
    if (UUT.u_adc_panel_assert.fail_count == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("%0d assertion failures seen", UUT.u_adc_panel_assert.fail_count);
      $display("Test failed");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_clock_gen.sv
/*
 * tb_clock_gen
 * free-running clock source for the testbench, period and start phase
 * set by parameters
 */

`default_nettype none

module tb_clock_gen #(
  parameter real period = 8.0,  // ns
  parameter real phase  = 0.0   // delay before the first toggle
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    #(phase);
    forever #(period / 2.0) clk = ~clk;  // 50 % duty
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/board_pkg.sv
hdl/key_debounce.sv
hdl/reset_pulse_stretcher.sv
hdl/heartbeat_blinker.sv
hdl/adc_channel_capture.sv
hdl/sample_display.sv
hdl/adc_panel_top.sv
tb/tb_clock_gen.sv
tb/adc_panel_assert.sv
tb/adc_panel_tb.sv
